// File: rtl/audio_defines.svh
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

// Playback commands held ahead of the fetch engine.
`define AUDIO_CMDQ_DEPTH 4

// Stereo frames buffered between fetch and output.
`define AUDIO_FIFO_DEPTH 4

// Register stages in the volume multiplier.
`define AUDIO_MUL_LATENCY 3

// Last step of the output sequencer.
// Left and right pass through the multiplier one after the other.
`define AUDIO_OUT_STEPS (2 * `AUDIO_MUL_LATENCY + 3)

// Sequencer step at which the left product is taken.
`define AUDIO_LEFT_STEP (`AUDIO_MUL_LATENCY + 2)

`endif

// File: rtl/audio_pkg.sv
package audio_pkg;

	// One signed PCM sample.
	typedef logic signed [15:0] sample_t;

	// Stereo frame, left sample in the upper half.
	typedef logic [31:0] frame_t;

	// Byte address on the memory bus.
	typedef logic [31:0] address_t;

	// Remaining samples (mono) or frames (stereo).
	typedef logic [23:0] count_t;

	// Playback volume, 0 to 15 sixteenths.
	typedef logic [3:0] volume_t;

	// Fetch engine states.
	typedef enum logic [2:0] {
		DMA_MONO_WAIT,
		DMA_MONO_REQUEST,
		DMA_MONO_ENQ_LO,
		DMA_MONO_ENQ_HI,
		DMA_STEREO_WAIT,
		DMA_STEREO_REQUEST,
		DMA_STEREO_ENQ
	} dma_state_t;

endpackage

// File: rtl/audio_cmd_queue.sv
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_cmd_queue (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_setup_request,
	input  logic                i_setup_append,
	input  logic                i_setup_stereo,
	input  audio_pkg::address_t i_setup_address,
	input  audio_pkg::count_t   i_setup_count,
	input  logic                i_next_ready,
	output logic                o_next_have,
	output logic                o_next_stereo,
	output audio_pkg::address_t o_next_address,
	output audio_pkg::count_t   o_next_count,
	output logic                o_busy
);
	import audio_pkg::*;

	localparam int DEPTH  = `AUDIO_CMDQ_DEPTH;
	localparam int PTR_W  = $clog2(DEPTH);
	localparam int USED_W = $clog2(DEPTH + 1);

	logic              stereo_q  [DEPTH];
	address_t          address_q [DEPTH];
	count_t            count_q   [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W-1:0]  wr_slot;
	logic [USED_W-1:0] used;
	logic              replace;
	logic              push;
	logic              pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign replace = i_setup_request && !i_setup_append;
	// Appends into a full queue are dropped.
	assign push    = i_setup_request && (!i_setup_append || used != USED_W'(DEPTH));
	assign pop     = i_next_ready && o_next_have;

	// A replace restarts the buffer at slot zero.
	assign wr_slot = replace ? '0 : wr_ptr;

	always_ff @(posedge i_clock) begin
		if (push) begin
			stereo_q[wr_slot]  <= i_setup_stereo;
			address_q[wr_slot] <= i_setup_address;
			count_q[wr_slot]   <= i_setup_count;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else if (replace) begin
			// Pending entries are discarded; the new one is the only entry.
			rd_ptr <= '0;
			wr_ptr <= ptr_next('0);
			used   <= USED_W'(1);
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({push, pop})
				2'b10:   used <= used + 1'b1;
				2'b01:   used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

	// Head entry.
	assign o_next_have    = (used != '0);
	assign o_next_stereo  = stereo_q[rd_ptr];
	assign o_next_address = address_q[rd_ptr];
	assign o_next_count   = count_q[rd_ptr];

	assign o_busy = (used != '0);

endmodule

// File: rtl/audio_sample_fifo.sv
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_sample_fifo (
	input  logic              i_clock,
	input  logic              i_reset,
	input  logic              i_write,
	input  audio_pkg::frame_t i_wdata,
	input  logic              i_read,
	output audio_pkg::frame_t o_rdata,
	output logic              o_empty,
	output logic              o_almost_full
);
	import audio_pkg::*;

	localparam int DEPTH  = `AUDIO_FIFO_DEPTH;
	localparam int PTR_W  = $clog2(DEPTH);
	localparam int USED_W = $clog2(DEPTH + 1);

	frame_t            mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [USED_W-1:0] used;
	logic              full;
	logic              wr_en;
	logic              rd_en;

	assign full          = (used == USED_W'(DEPTH));
	assign o_empty       = (used == '0);
	// One free slot or fewer, enough headroom for a mono word.
	assign o_almost_full = (used >= USED_W'(DEPTH - 1));

	assign wr_en = i_write && !full;
	assign rd_en = i_read && !o_empty;

	always_ff @(posedge i_clock) begin
		if (wr_en)
			mem[wr_ptr] <= i_wdata;
		if (rd_en)
			o_rdata <= mem[rd_ptr];
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   used <= used + 1'b1;
				2'b01:   used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

endmodule

// File: rtl/audio_volume_mul.sv
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_volume_mul (
	input  logic               i_clock,
	input  audio_pkg::sample_t i_sample,
	input  audio_pkg::volume_t i_volume,
	output audio_pkg::sample_t o_product
);
	import audio_pkg::*;

	localparam int LATENCY = `AUDIO_MUL_LATENCY;

	logic signed [20:0] product;
	sample_t            pipe [LATENCY];

	// Volume is unsigned, so it gets a zero sign bit.
	always_comb begin
		product = i_sample * $signed({1'b0, i_volume});
	end

	always_ff @(posedge i_clock) begin
		// Arithmetic shift right by 4; the product fits in 20 bits.
		pipe[0] <= product[19:4];
		for (int i = 1; i < LATENCY; i++) begin
			pipe[i] <= pipe[i-1];
		end
	end

	assign o_product = pipe[LATENCY-1];

endmodule

// File: rtl/audio_channel.sv
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_channel (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_setup_request,
	input  logic                i_setup_append,
	input  logic                i_setup_stereo,
	input  audio_pkg::address_t i_setup_address,
	input  audio_pkg::count_t   i_setup_count,
	output logic                o_dma_request,
	output audio_pkg::address_t o_dma_address,
	input  logic                i_dma_ready,
	input  logic [31:0]         i_dma_rdata,
	input  audio_pkg::volume_t  i_volume,
	input  logic                i_sample_clock,
	output audio_pkg::sample_t  o_left,
	output audio_pkg::sample_t  o_right,
	output logic                o_busy
);
	import audio_pkg::*;

	localparam int STEP_W = $clog2(`AUDIO_OUT_STEPS + 1);
	localparam logic [STEP_W-1:0] STEP_LEFT = STEP_W'(`AUDIO_LEFT_STEP);
	localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(`AUDIO_OUT_STEPS);

	// Command queue head.
	logic       next_have;
	logic       next_ready;
	logic       next_stereo;
	address_t   next_address;
	count_t     next_count;

	// Fetch engine.
	dma_state_t  dma_state;
	address_t    dma_address;
	count_t      dma_count;
	logic [31:0] dma_word;

	// Sample FIFO.
	logic   fifo_write;
	frame_t fifo_wdata;
	logic   fifo_read;
	frame_t fifo_rdata;
	logic   fifo_empty;
	logic   fifo_almost_full;

	// Output sequencer.
	logic              sclk_q;
	logic              sclk_prev;
	logic              sclk_edge;
	logic [STEP_W-1:0] step;
	sample_t           mul_sample;
	sample_t           mul_product;
	sample_t           left_hold;

	assign next_ready = (dma_count == '0);

	audio_cmd_queue cmd_queue (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_setup_request (i_setup_request),
		.i_setup_append  (i_setup_append),
		.i_setup_stereo  (i_setup_stereo),
		.i_setup_address (i_setup_address),
		.i_setup_count   (i_setup_count),
		.i_next_ready    (next_ready),
		.o_next_have     (next_have),
		.o_next_stereo   (next_stereo),
		.o_next_address  (next_address),
		.o_next_count    (next_count),
		.o_busy          (o_busy)
	);

	audio_sample_fifo sample_fifo (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_write       (fifo_write),
		.i_wdata       (fifo_wdata),
		.i_read        (fifo_read),
		.o_rdata       (fifo_rdata),
		.o_empty       (fifo_empty),
		.o_almost_full (fifo_almost_full)
	);

	audio_volume_mul volume_mul (
		.i_clock   (i_clock),
		.i_sample  (mul_sample),
		.i_volume  (i_volume),
		.o_product (mul_product)
	);

	assign o_dma_request = (dma_state == DMA_MONO_REQUEST) || (dma_state == DMA_STEREO_REQUEST);
	assign o_dma_address = dma_address;

	// Load a new command, or step through the current one.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			dma_state   <= DMA_MONO_WAIT;
			dma_count   <= '0;
			dma_address <= '0;
		end else if (next_have && next_ready) begin
			dma_state   <= next_stereo ? DMA_STEREO_WAIT : DMA_MONO_WAIT;
			dma_count   <= next_count;
			dma_address <= next_address;
		end else begin
			case (dma_state)
				DMA_MONO_WAIT: begin
					if (dma_count != '0 && !fifo_almost_full)
						dma_state <= DMA_MONO_REQUEST;
				end
				DMA_MONO_REQUEST: begin
					if (i_dma_ready)
						dma_state <= DMA_MONO_ENQ_LO;
				end
				DMA_MONO_ENQ_LO: begin
					dma_count <= dma_count - 1'b1;
					dma_state <= DMA_MONO_ENQ_HI;
				end
				DMA_MONO_ENQ_HI: begin
					dma_count   <= dma_count - 1'b1;
					dma_address <= dma_address + 32'd4;
					dma_state   <= DMA_MONO_WAIT;
				end
				DMA_STEREO_WAIT: begin
					if (dma_count != '0 && !fifo_almost_full)
						dma_state <= DMA_STEREO_REQUEST;
				end
				DMA_STEREO_REQUEST: begin
					if (i_dma_ready)
						dma_state <= DMA_STEREO_ENQ;
				end
				DMA_STEREO_ENQ: begin
					dma_count   <= dma_count - 1'b1;
					dma_address <= dma_address + 32'd4;
					dma_state   <= DMA_STEREO_WAIT;
				end
				default: dma_state <= DMA_MONO_WAIT;
			endcase
		end
	end

	// Read data is only valid with ready.
	always_ff @(posedge i_clock) begin
		if (o_dma_request && i_dma_ready)
			dma_word <= i_dma_rdata;
	end

	assign fifo_write = (dma_state == DMA_MONO_ENQ_LO) || (dma_state == DMA_MONO_ENQ_HI) ||
		(dma_state == DMA_STEREO_ENQ);

	// Mono duplicates each half-word to both sides, low half first.
	always_comb begin
		case (dma_state)
			DMA_MONO_ENQ_LO: fifo_wdata = {dma_word[15:0], dma_word[15:0]};
			DMA_MONO_ENQ_HI: fifo_wdata = {dma_word[31:16], dma_word[31:16]};
			default:         fifo_wdata = dma_word;
		endcase
	end

	assign sclk_edge = sclk_q ^ sclk_prev;
	assign fifo_read = sclk_edge && !fifo_empty;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sclk_q    <= 1'b0;
			sclk_prev <= 1'b0;
			step      <= '0;
			o_left    <= '0;
			o_right   <= '0;
		end else begin
			sclk_q    <= i_sample_clock;
			sclk_prev <= sclk_q;

			// Underflow gives silence.
			if (sclk_edge && fifo_empty) begin
				o_left  <= '0;
				o_right <= '0;
			end

			if (fifo_read)
				step <= STEP_W'(1);
			else if (step == STEP_LAST)
				step <= '0;
			else if (step != '0)
				step <= step + 1'b1;

			// Both sides change in the same cycle.
			if (step == STEP_LAST) begin
				o_left  <= left_hold;
				o_right <= mul_product;
			end
		end
	end

	// Left goes through the multiplier first, then right.
	always_ff @(posedge i_clock) begin
		if (step == STEP_W'(1))
			mul_sample <= fifo_rdata[31:16];
		if (step == STEP_LEFT) begin
			left_hold  <= mul_product;
			mul_sample <= fifo_rdata[15:0];
		end
	end

endmodule

// File: rtl/audio_top.sv
`timescale 1ns/1ps

module audio_top (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_setup_request,
	input  logic                i_setup_append,
	input  logic                i_setup_stereo,
	input  audio_pkg::address_t i_setup_address,
	input  audio_pkg::count_t   i_setup_count,
	output logic                o_dma_request,
	output audio_pkg::address_t o_dma_address,
	input  logic                i_dma_ready,
	input  logic [31:0]         i_dma_rdata,
	input  audio_pkg::volume_t  i_volume,
	input  logic                i_sample_clock,
	output audio_pkg::sample_t  o_left,
	output audio_pkg::sample_t  o_right,
	output logic                o_busy
);

	// Single playback channel.
	audio_channel channel (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_setup_request (i_setup_request),
		.i_setup_append  (i_setup_append),
		.i_setup_stereo  (i_setup_stereo),
		.i_setup_address (i_setup_address),
		.i_setup_count   (i_setup_count),
		.o_dma_request   (o_dma_request),
		.o_dma_address   (o_dma_address),
		.i_dma_ready     (i_dma_ready),
		.i_dma_rdata     (i_dma_rdata),
		.i_volume        (i_volume),
		.i_sample_clock  (i_sample_clock),
		.o_left          (o_left),
		.o_right         (o_right),
		.o_busy          (o_busy)
	);

endmodule

// File: testbench/audio_chk.sv
`timescale 1ns/1ps

module audio_chk (
	input logic                i_clock,
	input logic                i_reset,
	input logic                i_dma_request,
	input audio_pkg::address_t i_dma_address,
	input logic                i_dma_ready,
	input logic                i_fifo_write,
	input logic                i_fifo_full,
	input audio_pkg::sample_t  i_left,
	input audio_pkg::sample_t  i_right,
	input logic                i_busy
);

	// Count of failed assertions.
	int unsigned fail_count = 0;

	// Request and address hold until ready.
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_dma_request && !i_dma_ready |=> i_dma_request && $stable(i_dma_address))
	else begin
		fail_count++;
		$error("DMA request or address changed before ready");
	end

	// Request drops for at least the cycle after ready.
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_dma_request && i_dma_ready |=> !i_dma_request)
	else begin
		fail_count++;
		$error("DMA request still high after ready");
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		i_dma_request |-> i_dma_address[1:0] == 2'b00)
	else begin
		fail_count++;
		$error("DMA address is not word aligned");
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_fifo_write && i_fifo_full))
	else begin
		fail_count++;
		$error("Sample FIFO written while full");
	end

	assert property (@(posedge i_clock)
		i_reset |=> i_left == '0 && i_right == '0 && !i_dma_request && !i_busy)
	else begin
		fail_count++;
		$error("Outputs not cleared by reset");
	end

endmodule

bind audio_top audio_chk chk (
	.i_clock       (i_clock),
	.i_reset       (i_reset),
	.i_dma_request (o_dma_request),
	.i_dma_address (o_dma_address),
	.i_dma_ready   (i_dma_ready),
	.i_fifo_write  (channel.fifo_write),
	.i_fifo_full   (channel.sample_fifo.full),
	.i_left        (o_left),
	.i_right       (o_right),
	.i_busy        (o_busy)
);

// File: testbench/audio_tb.sv
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_tb;
	import audio_pkg::*;

	// Output update is visible on the falling edge this many cycles after a toggle.
	localparam int CHECK_DELAY    = 2 * `AUDIO_MUL_LATENCY + 5;
	localparam int MIN_GAP        = 2 * `AUDIO_MUL_LATENCY + 6;
	localparam int TOTAL_COUNT    = 8 + 8 + 16 + 12 + 8 + 4 + 4 + 6;
	localparam int TIMEOUT_CYCLES = TOTAL_COUNT * 40 + 2000;
	// Volumes 0, 1, 8 and 15, one nibble each.
	localparam logic [15:0] VOLUME_STEPS = 16'hF810;

	localparam address_t STEREO_BASE   = 32'h0001_0040;
	localparam address_t MONO_BASE     = 32'h0002_0100;
	localparam address_t VOLUME_BASE   = 32'h0001_FFE0;
	localparam address_t APPEND_BASE_A = 32'h0003_0000;
	localparam address_t APPEND_BASE_B = 32'h0003_8000;
	localparam address_t REPLACE_BASE  = 32'h0004_0000;

	logic        i_clock = 1'b0;
	logic        i_reset = 1'b1;
	logic        i_setup_request = 1'b0;
	logic        i_setup_append = 1'b1;
	logic        i_setup_stereo = 1'b0;
	address_t    i_setup_address = '0;
	count_t      i_setup_count = '0;
	logic        o_dma_request;
	address_t    o_dma_address;
	logic        i_dma_ready = 1'b0;
	logic [31:0] i_dma_rdata = '0;
	volume_t     i_volume = 4'd15;
	logic        i_sample_clock = 1'b0;
	sample_t     o_left;
	sample_t     o_right;
	logic        o_busy;

	frame_t expected [$];
	int     mem_delay = -1;
	int     words_served = 0;
	int     error_count = 0;
	int     check_count = 0;
	int     test_count = 0;

	audio_top uut (.*);

	always #2 i_clock = ~i_clock;

	function automatic logic [31:0] memory_word(input address_t address);
		return {address[17:2], ~address[17:2]};
	endfunction

	function automatic sample_t scaled(input sample_t sample, input volume_t volume);
		int product;
		product = int'(sample) * int'(volume);
		return sample_t'(product >>> 4);
	endfunction

	function automatic int failures();
		return error_count + int'(uut.chk.fail_count);
	endfunction

	// Memory answers each request after 0 to 5 cycles.
	always @(negedge i_clock) begin
		if (i_dma_ready || i_reset || !o_dma_request) begin
			i_dma_ready = 1'b0;
			mem_delay = -1;
		end else begin
			if (mem_delay < 0)
				mem_delay = int'($urandom_range(5, 0));
			if (mem_delay == 0) begin
				i_dma_ready = 1'b1;
				i_dma_rdata = memory_word(o_dma_address);
				words_served++;
			end else begin
				mem_delay--;
			end
		end
	end

	task automatic check_value(input string name, input int actual, input int want);
		check_count++;
		assert (actual == want) else begin
			error_count++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, actual, want);
		end
	endtask

	task automatic issue_command(input logic append, input logic stereo, input address_t address,
		input count_t count, input logic played);
		logic [31:0] word;
		@(negedge i_clock);
		i_setup_request = 1'b1;
		i_setup_append  = append;
		i_setup_stereo  = stereo;
		i_setup_address = address;
		i_setup_count   = count;
		@(negedge i_clock);
		i_setup_request = 1'b0;
		check_value("o_busy", int'(o_busy), 1);
		// Mono plays low half then high half of each word.
		for (int i = 0; played && i < int'(count); i++) begin
			word = memory_word(address + address_t'(4 * (stereo ? i : i / 2)));
			if (stereo)
				expected.push_back(word);
			else if (i % 2 == 0)
				expected.push_back({word[15:0], word[15:0]});
			else
				expected.push_back({word[31:16], word[31:16]});
		end
	endtask

	// Toggle the sample clock and check the resulting output pair.
	task automatic play_frame();
		frame_t  raw;
		sample_t exp_left;
		sample_t exp_right;
		int      gap;
		gap = MIN_GAP + int'($urandom_range(4, 0));
		i_sample_clock = ~i_sample_clock;
		exp_left  = '0;
		exp_right = '0;
		if (expected.size() > 0) begin
			raw = expected.pop_front();
			exp_left  = scaled(raw[31:16], i_volume);
			exp_right = scaled(raw[15:0], i_volume);
		end
		repeat (CHECK_DELAY) @(negedge i_clock);
		check_value("o_left", int'(o_left), int'(exp_left));
		check_value("o_right", int'(o_right), int'(exp_right));
		repeat (gap - CHECK_DELAY) @(negedge i_clock);
	endtask

	task automatic finish_test(input string name, input int mark);
		test_count++;
		$display("Test %0d %s: %0d failures", test_count, name, failures() - mark);
	endtask

	initial begin
		int mark;
		int base;
		void'($urandom(72));
		repeat (3) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;

		mark = failures();
		base = words_served;
		issue_command(1'b1, 1'b1, STEREO_BASE, 24'd8, 1'b1);
		wait (words_served >= base + 2);
		repeat (8) play_frame();
		finish_test("stereo playback", mark);

		mark = failures();
		base = words_served;
		issue_command(1'b1, 1'b0, MONO_BASE, 24'd8, 1'b1);
		wait (words_served >= base + 2);
		repeat (8) play_frame();
		finish_test("mono playback", mark);

		// Addresses cross bit 17, so both halves change sign.
		mark = failures();
		base = words_served;
		issue_command(1'b1, 1'b1, VOLUME_BASE, 24'd16, 1'b1);
		wait (words_served >= base + 2);
		for (int n = 0; n < 4; n++) begin
			i_volume = VOLUME_STEPS[n*4 +: 4];
			repeat (4) play_frame();
		end
		finish_test("volume", mark);

		mark = failures();
		repeat (2) play_frame();
		finish_test("underflow", mark);

		mark = failures();
		base = words_served;
		issue_command(1'b1, 1'b1, APPEND_BASE_A, 24'd6, 1'b1);
		issue_command(1'b1, 1'b0, APPEND_BASE_B, 24'd6, 1'b1);
		wait (words_served >= base + 2);
		fork
			repeat (12) play_frame();
			begin
				wait (!o_busy);
				check_count++;
				assert (words_served - base >= 6) else begin
					error_count++;
					$display("o_busy fell before the first command was fully fetched");
				end
			end
		join
		check_value("o_busy", int'(o_busy), 0);
		finish_test("append and busy", mark);

		// Two pending commands are dropped by the replace.
		mark = failures();
		base = words_served;
		issue_command(1'b1, 1'b1, REPLACE_BASE, 24'd8, 1'b1);
		wait (words_served >= base + 2);
		issue_command(1'b1, 1'b1, REPLACE_BASE + 32'h1000, 24'd4, 1'b0);
		issue_command(1'b1, 1'b0, REPLACE_BASE + 32'h2000, 24'd4, 1'b0);
		issue_command(1'b0, 1'b1, REPLACE_BASE + 32'h3000, 24'd6, 1'b1);
		// Last toggle must find the FIFO empty.
		repeat (15) play_frame();
		check_value("o_busy", int'(o_busy), 0);
		finish_test("replace", mark);

		$display("Tests %0d, checks %0d, failures %0d", test_count, check_count, failures());
		if (failures() == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge i_clock);
		$display("Watchdog timeout after %0d cycles", TIMEOUT_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+rtl
rtl/audio_pkg.sv
rtl/audio_cmd_queue.sv
rtl/audio_sample_fifo.sv
rtl/audio_volume_mul.sv
rtl/audio_channel.sv
rtl/audio_top.sv
testbench/audio_chk.sv
testbench/audio_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the audio channel testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sim.f --top-module audio_tb -o audio_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Keep running after a failed assertion so the testbench can report it.
output=$(./obj_dir/audio_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1
